//--- design/lcd_pkg.sv
// shared types, panel geometry and command codes, imported by every LCD block and the testbench
package lcd_pkg;

    // panel geometry in pixels
    localparam int LCD_W        = 32;
    localparam int LCD_H        = 16;
    localparam int CHAR_X0      = 8;  // top-left corner of the character window
    localparam int CHAR_Y0      = 4;
    localparam int GLYPH_SIZE   = 8;
    localparam int GLYPH_CNT    = 4;  // glyphs held in the ROM

    localparam int FILL_WORDS   = LCD_W * LCD_H;
    localparam int GLYPH_PIXELS = GLYPH_SIZE * GLYPH_SIZE;
    localparam int WIN_WORDS    = 7;  // col cmd, x0, x1, row cmd, y0, y1, mem write

    // 8080 strobe phases, in pclk cycles
    localparam int WR_LOW_CYC   = 2;
    localparam int WR_HIGH_CYC  = 2;

    localparam string GLYPH_FILE = "design/glyph_rom.hex";

    // rgb565 color, also carries command codes and window coordinates
    typedef logic [15:0] pixel_t;

    typedef logic [$clog2(GLYPH_CNT)-1:0]    glyph_code_t;
    typedef logic [$clog2(GLYPH_PIXELS)-1:0] pix_idx_t;
    typedef logic [$clog2(FILL_WORDS)-1:0]   fill_cnt_t;

    // one bus transfer, rs = 0 for a command and 1 for data
    typedef struct packed {
        logic   rs;
        pixel_t value;
    } lcd_word_t;

    // panel commands
    localparam pixel_t CMD_COL_ADDR  = 16'h002A;
    localparam pixel_t CMD_ROW_ADDR  = 16'h002B;
    localparam pixel_t CMD_MEM_WRITE = 16'h002C;

endpackage

//--- design/lcd_char_render.sv
// glyph renderer: turns a character code into 64 fg/bg pixels, stepped by the sequencer
`timescale 1ns/1ps

module lcd_char_render
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n_i,
    input  logic        render_start_i,
    input  glyph_code_t char_code_i,
    input  pixel_t      fg_color_i,
    input  pixel_t      bg_color_i,
    input  logic        pix_next_i,
    output pixel_t      pix_o,
    output logic        pix_last_o
);

    localparam int ROM_DEPTH = GLYPH_CNT * GLYPH_SIZE;
    localparam int ROW_W     = $clog2(GLYPH_SIZE);

    logic [GLYPH_SIZE-1:0] glyph_rom [0:ROM_DEPTH-1];  // one byte per glyph row

    glyph_code_t           code_q;
    pixel_t                fg_q;
    pixel_t                bg_q;
    pix_idx_t              pix_cnt;
    logic [ROW_W-1:0]      row;
    logic [ROW_W-1:0]      col;
    logic [GLYPH_SIZE-1:0] row_bits;
    logic                  pix_on;

    initial begin
        $readmemh(GLYPH_FILE, glyph_rom);
    end

    // row major, msb of each row byte is the leftmost pixel
    assign row      = pix_cnt[2*ROW_W-1:ROW_W];
    assign col      = pix_cnt[ROW_W-1:0];
    assign row_bits = glyph_rom[{code_q, row}];
    assign pix_on   = row_bits[(GLYPH_SIZE - 1) - col];

    assign pix_o      = pix_on ? fg_q : bg_q;
    assign pix_last_o = (pix_cnt == pix_idx_t'(GLYPH_PIXELS - 1));

    always_ff @(posedge pclk) begin
        if (render_start_i) begin
            code_q <= char_code_i;
            fg_q   <= fg_color_i;
            bg_q   <= bg_color_i;
        end
    end

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pix_cnt <= '0;
        end else if (render_start_i) begin
            pix_cnt <= '0;
        end else if (pix_next_i) begin
            pix_cnt <= pix_cnt + 1'b1;  // wraps after the last pixel
        end
    end

endmodule

//--- design/lcd_bus_writer.sv
// 8080 bus writer: one strobed panel word per four-phase req/ack request from the sequencer
`timescale 1ns/1ps

module lcd_bus_writer
    import lcd_pkg::*;
(
    input  logic      pclk,
    input  logic      rst_n_i,
    input  logic      wr_req_i,
    input  lcd_word_t wr_word_i,
    output logic      wr_ack_o,
    output logic      lcd_cs_n_o,
    output logic      lcd_rs_o,
    output logic      lcd_wr_n_o,
    output pixel_t    lcd_data_o
);

    typedef enum logic [1:0] {
        IDLE,
        STROBE_LOW,
        STROBE_HIGH,
        ACK
    } wr_state_t;

    wr_state_t  state;
    logic [2:0] phase_cnt;  // cycles spent in the current strobe phase

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state      <= IDLE;
            phase_cnt  <= '0;
            wr_ack_o   <= 1'b0;
            lcd_cs_n_o <= 1'b1;
            lcd_wr_n_o <= 1'b1;
            lcd_rs_o   <= 1'b0;
            lcd_data_o <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_req_i) begin
                        lcd_cs_n_o <= 1'b0;
                        lcd_wr_n_o <= 1'b0;
                        lcd_rs_o   <= wr_word_i.rs;
                        lcd_data_o <= wr_word_i.value;
                        phase_cnt  <= '0;
                        state      <= STROBE_LOW;
                    end
                end
                STROBE_LOW: begin
                    if (phase_cnt == 3'(WR_LOW_CYC - 1)) begin
                        lcd_wr_n_o <= 1'b1;  // panel samples on this edge
                        phase_cnt  <= '0;
                        state      <= STROBE_HIGH;
                    end else begin
                        phase_cnt <= phase_cnt + 3'd1;
                    end
                end
                STROBE_HIGH: begin
                    if (phase_cnt == 3'(WR_HIGH_CYC - 1)) begin
                        wr_ack_o <= 1'b1;
                        state    <= ACK;
                    end else begin
                        phase_cnt <= phase_cnt + 3'd1;
                    end
                end
                ACK: begin
                    // return to zero once the sequencer lets go
                    if (!wr_req_i) begin
                        wr_ack_o   <= 1'b0;
                        lcd_cs_n_o <= 1'b1;
                        lcd_rs_o   <= 1'b0;
                        lcd_data_o <= '0;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- design/lcd_seq_ctrl.sv
// frame sequencer: sets the windows, fills the panel, streams the glyph pixels to the bus writer
`timescale 1ns/1ps

module lcd_seq_ctrl
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n_i,
    input  logic        cpu_work_i,
    input  glyph_code_t char_code_i,
    input  pixel_t      fg_color_i,
    input  pixel_t      bg_color_i,
    output logic        wr_req_o,
    output lcd_word_t   wr_word_o,
    input  logic        wr_ack_i,
    output logic        render_start_o,
    output logic        pix_next_o,
    input  pixel_t      char_pix_i,
    input  logic        pix_last_i,
    output logic        done_o
);

    typedef enum logic [2:0] {
        IDLE,
        FILL_WIN,
        FILL_DATA,
        CHAR_WIN,
        CHAR_DATA,
        FINISHED
    } seq_state_t;

    seq_state_t state;
    logic [2:0] win_idx;   // position within the seven setup words
    fill_cnt_t  fill_cnt;
    pixel_t     bg_q;      // background sampled at frame start
    logic       wr_pend;   // a word is still owned by the writer
    logic       sending;
    logic       can_issue;
    logic       word_acked;
    lcd_word_t  next_word;

    // setup word for the full panel or the character window
    function automatic lcd_word_t win_word(input logic [2:0] idx, input logic char_win);
        pixel_t    x0;
        pixel_t    x1;
        pixel_t    y0;
        pixel_t    y1;
        lcd_word_t w;
        x0 = char_win ? pixel_t'(CHAR_X0) : '0;
        x1 = char_win ? pixel_t'(CHAR_X0 + GLYPH_SIZE - 1) : pixel_t'(LCD_W - 1);
        y0 = char_win ? pixel_t'(CHAR_Y0) : '0;
        y1 = char_win ? pixel_t'(CHAR_Y0 + GLYPH_SIZE - 1) : pixel_t'(LCD_H - 1);
        case (idx)
            3'd0:    w = '{rs: 1'b0, value: CMD_COL_ADDR};
            3'd1:    w = '{rs: 1'b1, value: x0};
            3'd2:    w = '{rs: 1'b1, value: x1};
            3'd3:    w = '{rs: 1'b0, value: CMD_ROW_ADDR};
            3'd4:    w = '{rs: 1'b1, value: y0};
            3'd5:    w = '{rs: 1'b1, value: y1};
            default: w = '{rs: 1'b0, value: CMD_MEM_WRITE};
        endcase
        return w;
    endfunction

    assign sending    = state inside {FILL_WIN, FILL_DATA, CHAR_WIN, CHAR_DATA};
    // wait for the previous word, even one left over from an abort
    assign can_issue  = cpu_work_i && sending && !wr_pend && !wr_ack_i;
    assign word_acked = wr_req_o && wr_ack_i;

    always_comb begin
        case (state)
            FILL_WIN:  next_word = win_word(win_idx, 1'b0);
            CHAR_WIN:  next_word = win_word(win_idx, 1'b1);
            FILL_DATA: next_word = '{rs: 1'b1, value: bg_q};
            CHAR_DATA: next_word = '{rs: 1'b1, value: char_pix_i};
            default:   next_word = '0;
        endcase
    end

    // held until the writer has acked, also across an abort
    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_pend <= 1'b0;
        end else if (can_issue) begin
            wr_pend <= 1'b1;
        end else if (wr_ack_i) begin
            wr_pend <= 1'b0;
        end
    end

    always_ff @(posedge pclk) begin
        if (can_issue) begin
            wr_word_o <= next_word;  // stable while req is high
        end
        if (state == IDLE && cpu_work_i) begin
            bg_q <= bg_color_i;
        end
    end

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state          <= IDLE;
            wr_req_o       <= 1'b0;
            win_idx        <= '0;
            fill_cnt       <= '0;
            render_start_o <= 1'b0;
            pix_next_o     <= 1'b0;
            done_o         <= 1'b0;
        end else if (!cpu_work_i) begin
            // abort or wait for enable
            state          <= IDLE;
            wr_req_o       <= 1'b0;
            render_start_o <= 1'b0;
            pix_next_o     <= 1'b0;
            done_o         <= 1'b0;
        end else begin
            render_start_o <= 1'b0;
            pix_next_o     <= 1'b0;
            if (can_issue) begin
                wr_req_o <= 1'b1;
            end else if (word_acked) begin
                wr_req_o <= 1'b0;
            end

            case (state)
                IDLE: begin
                    render_start_o <= 1'b1;  // renderer samples code and colors now
                    win_idx        <= '0;
                    fill_cnt       <= '0;
                    state          <= FILL_WIN;
                end
                FILL_WIN, CHAR_WIN: begin
                    if (word_acked) begin
                        if (win_idx == 3'(WIN_WORDS - 1)) begin
                            win_idx <= '0;
                            state   <= (state == FILL_WIN) ? FILL_DATA : CHAR_DATA;
                        end else begin
                            win_idx <= win_idx + 3'd1;
                        end
                    end
                end
                FILL_DATA: begin
                    if (word_acked) begin
                        if (fill_cnt == fill_cnt_t'(FILL_WORDS - 1)) begin
                            state <= CHAR_WIN;
                        end else begin
                            fill_cnt <= fill_cnt + 1'b1;
                        end
                    end
                end
                CHAR_DATA: begin
                    if (word_acked) begin
                        pix_next_o <= 1'b1;  // step renderer to the next pixel
                        if (pix_last_i) begin
                            state  <= FINISHED;
                            done_o <= 1'b1;
                        end
                    end
                end
                FINISHED: state <= FINISHED;  // hold until enable drops
                default:  state <= IDLE;
            endcase
        end
    end

endmodule

//--- design/lcd_subsys_top.sv
// LCD front end top: ties the sequencer, glyph renderer and bus writer to the panel pins
`timescale 1ns/1ps

module lcd_subsys_top
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n_i,
    input  logic        cpu_work_i,
    input  glyph_code_t char_code_i,
    input  pixel_t      fg_color_i,
    input  pixel_t      bg_color_i,
    output logic        lcd_cs_n_o,
    output logic        lcd_rs_o,
    output logic        lcd_wr_n_o,
    output pixel_t      lcd_data_o,
    output logic        done_o
);

    logic      wr_req;
    lcd_word_t wr_word;
    logic      wr_ack;
    logic      render_start;
    logic      pix_next;
    pixel_t    char_pix;
    logic      pix_last;

    lcd_seq_ctrl u_seq_ctrl (
        .pclk           (pclk),
        .rst_n_i        (rst_n_i),
        .cpu_work_i     (cpu_work_i),
        .char_code_i    (char_code_i),
        .fg_color_i     (fg_color_i),
        .bg_color_i     (bg_color_i),
        .wr_req_o       (wr_req),
        .wr_word_o      (wr_word),
        .wr_ack_i       (wr_ack),
        .render_start_o (render_start),
        .pix_next_o     (pix_next),
        .char_pix_i     (char_pix),
        .pix_last_i     (pix_last),
        .done_o         (done_o)
    );

    // code and colors are latched on render_start at frame start
    lcd_char_render u_char_render (
        .pclk           (pclk),
        .rst_n_i        (rst_n_i),
        .render_start_i (render_start),
        .char_code_i    (char_code_i),
        .fg_color_i     (fg_color_i),
        .bg_color_i     (bg_color_i),
        .pix_next_i     (pix_next),
        .pix_o          (char_pix),
        .pix_last_o     (pix_last)
    );

    lcd_bus_writer u_bus_writer (
        .pclk       (pclk),
        .rst_n_i    (rst_n_i),
        .wr_req_i   (wr_req),
        .wr_word_i  (wr_word),
        .wr_ack_o   (wr_ack),
        .lcd_cs_n_o (lcd_cs_n_o),
        .lcd_rs_o   (lcd_rs_o),
        .lcd_wr_n_o (lcd_wr_n_o),
        .lcd_data_o (lcd_data_o)
    );

endmodule

//--- sim/tb_lcd_subsys.sv
// testbench for the LCD front end, random frames checked word by word against a panel bus model
`timescale 1ns/1ps

module tb_lcd_subsys
    import lcd_pkg::*;
();

    localparam int SEED        = 54;
    localparam int FRAME_WORDS = 2 * WIN_WORDS + FILL_WORDS + GLYPH_PIXELS;  // 590
    localparam int TIMEOUT_CYC = 5 * FRAME_WORDS * 10 + 4000;

    logic        pclk;
    logic        rst_n_i;
    logic        cpu_work_i;
    glyph_code_t char_code_i;
    pixel_t      fg_color_i;
    pixel_t      bg_color_i;
    logic        lcd_cs_n_o;
    logic        lcd_rs_o;
    logic        lcd_wr_n_o;
    pixel_t      lcd_data_o;
    logic        done_o;

    logic [7:0]  glyph_mem [0:GLYPH_CNT*GLYPH_SIZE-1];  // model copy of the glyph ROM
    lcd_word_t   exp_q [$];         // words still expected in this frame
    logic        mon_on = 1'b0;     // monitor compares only while set
    int          strobe_total = 0;  // every wr_n rising edge
    int          frame_words = 0;
    int          cyc_cnt = 0;

    lcd_subsys_top dut0 (
        .pclk        (pclk),
        .rst_n_i     (rst_n_i),
        .cpu_work_i  (cpu_work_i),
        .char_code_i (char_code_i),
        .fg_color_i  (fg_color_i),
        .bg_color_i  (bg_color_i),
        .lcd_cs_n_o  (lcd_cs_n_o),
        .lcd_rs_o    (lcd_rs_o),
        .lcd_wr_n_o  (lcd_wr_n_o),
        .lcd_data_o  (lcd_data_o),
        .done_o      (done_o)
    );

    initial begin
        pclk = 1'b0;
        forever #4 pclk = ~pclk;
    end

    initial begin
        $readmemh(GLYPH_FILE, glyph_mem);
    end

    task automatic check_val(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("CHECK FAILED at %0t ns: %s expected 0x%0h actual 0x%0h",
                     $time, name, exp_val, act_val);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic push_word(input logic rs, input pixel_t value);
        lcd_word_t w;
        w.rs    = rs;
        w.value = value;
        exp_q.push_back(w);
    endtask

    // column range, row range, then memory write
    task automatic push_window(input int x0, input int x1, input int y0, input int y1);
        push_word(1'b0, CMD_COL_ADDR);
        push_word(1'b1, pixel_t'(x0));
        push_word(1'b1, pixel_t'(x1));
        push_word(1'b0, CMD_ROW_ADDR);
        push_word(1'b1, pixel_t'(y0));
        push_word(1'b1, pixel_t'(y1));
        push_word(1'b0, CMD_MEM_WRITE);
    endtask

    function automatic pixel_t glyph_color(input glyph_code_t code, input int idx,
                                           input pixel_t fg, input pixel_t bg);
        logic [7:0] row_bits;
        row_bits = glyph_mem[int'(code) * GLYPH_SIZE + idx / GLYPH_SIZE];
        return row_bits[GLYPH_SIZE - 1 - idx % GLYPH_SIZE] ? fg : bg;  // msb is left
    endfunction

    task automatic build_frame(input glyph_code_t code, input pixel_t fg, input pixel_t bg);
        int i;
        exp_q.delete();
        push_window(0, LCD_W - 1, 0, LCD_H - 1);
        for (i = 0; i < FILL_WORDS; i++) begin
            push_word(1'b1, bg);
        end
        push_window(CHAR_X0, CHAR_X0 + GLYPH_SIZE - 1, CHAR_Y0, CHAR_Y0 + GLYPH_SIZE - 1);
        for (i = 0; i < GLYPH_PIXELS; i++) begin
            push_word(1'b1, glyph_color(code, i, fg, bg));
        end
    endtask

    // new random code and colors, held for the whole frame
    task automatic start_frame();
        glyph_code_t code;
        pixel_t      fg;
        pixel_t      bg;
        code = glyph_code_t'($urandom);
        fg   = pixel_t'($urandom);
        bg   = pixel_t'($urandom);
        @(posedge pclk);
        #1;
        build_frame(code, fg, bg);
        frame_words = 0;
        mon_on      = 1'b1;
        char_code_i = code;
        fg_color_i  = fg;
        bg_color_i  = bg;
        cpu_work_i  = 1'b1;
    endtask

    task automatic wait_done();
        @(posedge pclk);
        #1;
        while (done_o !== 1'b1) begin
            @(posedge pclk);
            #1;
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge pclk);
            #1;
            check_val("lcd_cs_n_o", 1, lcd_cs_n_o);
            check_val("lcd_wr_n_o", 1, lcd_wr_n_o);
            check_val("lcd_data_o", 0, lcd_data_o);
            check_val("done_o", 0, done_o);
        end
    endtask

    // done only after the full frame, quiet bus while it is high
    task automatic check_frame_end();
        int strobes_at_done;
        check_val("words per frame", FRAME_WORDS, frame_words);
        check_val("expected words left", 0, exp_q.size());
        strobes_at_done = strobe_total;
        repeat (10) begin
            @(posedge pclk);
            #1;
            check_val("done_o", 1, done_o);
        end
        check_val("lcd_wr_n_o strobes while done", strobes_at_done, strobe_total);
        cpu_work_i = 1'b0;
        @(posedge pclk);
        #1;
        check_val("done_o", 0, done_o);
    endtask

    task automatic abort_fill();
        int abort_at;
        int drop_delay;
        int strobes_at_drop;
        abort_at   = WIN_WORDS + 1 + int'($urandom % (FILL_WORDS - 2));
        drop_delay = int'($urandom % 8);  // anywhere inside the next word
        start_frame();
        while (frame_words < abort_at) begin
            @(posedge pclk);
            #1;
        end
        repeat (drop_delay) begin
            @(posedge pclk);
            #1;
        end
        mon_on          = 1'b0;  // words from here on are not compared
        cpu_work_i      = 1'b0;
        strobes_at_drop = strobe_total;
        repeat (20) begin  // room for two more words if the sequencer kept going
            @(posedge pclk);
        end
        #1;
        check_val("lcd_wr_n_o at most one strobe after abort", 1,
                  32'(strobe_total - strobes_at_drop <= 1));
        check_idle(8);
    endtask

    // panel samples rs and data on the rising edge of wr_n
    always @(posedge lcd_wr_n_o) begin
        lcd_word_t exp_w;
        strobe_total++;
        if (mon_on) begin
            if (exp_q.size() == 0) begin
                $display("unexpected panel write at %0t ns after the frame was complete", $time);
                $display("Regression failed");
                $fatal(1, "extra panel write");
            end else begin
                exp_w = exp_q.pop_front();
                check_val($sformatf("lcd_rs_o word %0d", frame_words), exp_w.rs, lcd_rs_o);
                check_val($sformatf("lcd_data_o word %0d", frame_words), exp_w.value,
                          lcd_data_o);
                check_val($sformatf("lcd_cs_n_o word %0d", frame_words), 0, lcd_cs_n_o);
                check_val("done_o during frame", 0, done_o);
                frame_words++;
            end
        end
    end

    initial begin
        while (cyc_cnt < TIMEOUT_CYC) begin
            @(posedge pclk);
            cyc_cnt++;
        end
        $display("timeout after %0d cycles before all frames were finished", cyc_cnt);
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(SEED));
        rst_n_i     = 1'b0;
        cpu_work_i  = 1'b0;
        char_code_i = '0;
        fg_color_i  = '0;
        bg_color_i  = '0;
        repeat (4) begin
            @(posedge pclk);
        end
        #1;
        rst_n_i = 1'b1;

        check_idle(20);  // enable still low

        // first frame, then three more back to back
        start_frame();
        wait_done();
        check_frame_end();
        repeat (3) begin
            start_frame();
            wait_done();
            check_frame_end();
        end

        abort_fill();
        start_frame();  // restart from the full screen window
        wait_done();
        check_frame_end();

        $display("Regression passed");
        $finish;
    end

endmodule

//--- design/glyph_rom.hex
// each line is one glyph row of 8 pixels with the msb as the leftmost pixel
// four glyphs of eight rows follow in code order 0 to 3
18
24
42
42
7E
42
42
00
7C
42
42
7C
42
42
7C
00
3C
42
40
40
40
42
3C
00
FF
81
A5
81
BD
99
81
FF

//--- lcd_subsys_top.f
design/lcd_pkg.sv
design/lcd_char_render.sv
design/lcd_bus_writer.sv
design/lcd_seq_ctrl.sv
design/lcd_subsys_top.sv
sim/tb_lcd_subsys.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_lcd_subsys \
		-f lcd_subsys_top.f -o Vtb_lcd_subsys
	./obj_dir/Vtb_lcd_subsys

clean:
	rm -rf obj_dir
